//--- dcache.f
design/dcache_pkg.sv
design/dcache_ctrl.sv
design/flush_counter.sv
design/dcache_array.sv
design/lru_table.sv
design/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv

//--- design/dcache_array.sv
//////////////////////////////////////////////////
// tag, data, valid and dirty storage
// two-way tag compare at the request index
// store hit and fill word write ports
// block readout for writeback and flush
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dcache_array (
	input  logic CLK,
	input  logic nRST,
	input  dcache_pkg::dcache_addr_t req_addr,
	input  dcache_pkg::word_t dmem_store,
	input  dcache_pkg::word_t fill_data,
	input  logic wr_hit,
	input  logic [dcache_pkg::BLK_WORDS-1:0] fill_word,
	input  logic fill_way,
	input  logic set_valid,
	input  logic clr_dirty,
	input  logic flush_mode,
	input  logic [3:0] blk_sel,
	output logic hit,
	output logic hit_way,
	output logic blk_dirty,
	output logic [dcache_pkg::DTAG_W-1:0] blk_tag,
	output dcache_pkg::word_t [dcache_pkg::BLK_WORDS-1:0] blk_data,
	output logic [dcache_pkg::NUM_WAYS-1:0] valid_pair
);
	import dcache_pkg::*;

	logic [DTAG_W-1:0] tag_mem [NUM_SETS][NUM_WAYS];
	word_t [BLK_WORDS-1:0] data_mem [NUM_SETS][NUM_WAYS];
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;

	logic [DIDX_W-1:0] ridx;
	logic [DIDX_W-1:0] rd_idx;
	logic rd_way;
	logic [NUM_WAYS-1:0] way_hit;

	assign ridx = req_addr.fields.idx;

	// tag compare on both ways
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++)
			way_hit[w] = valid_q[ridx][w] && (tag_mem[ridx][w] == req_addr.fields.tag);
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];
	assign valid_pair = valid_q[ridx];

	// flush walks by counter, otherwise the way picked by the controller
	assign rd_idx = flush_mode ? blk_sel[DIDX_W-1:0] : ridx;
	assign rd_way = flush_mode ? blk_sel[3] : fill_way;

	assign blk_tag = tag_mem[rd_idx][rd_way];
	assign blk_data = data_mem[rd_idx][rd_way];
	assign blk_dirty = dirty_q[rd_idx][rd_way];

	always_ff @(posedge CLK) begin
		for (int k = 0; k < BLK_WORDS; k++) begin
			if (fill_word[k])
				data_mem[ridx][fill_way][k] <= fill_data; // word from the bus
		end
		if (wr_hit)
			data_mem[ridx][fill_way][req_addr.fields.blkoff] <= dmem_store;
		if (set_valid)
			tag_mem[ridx][fill_way] <= req_addr.fields.tag;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (clr_dirty)
				dirty_q[rd_idx][rd_way] <= 1'b0;
			if (set_valid) begin
				valid_q[ridx][fill_way] <= 1'b1;
				dirty_q[ridx][fill_way] <= 1'b0; // fresh block is clean
			end
			if (wr_hit)
				dirty_q[ridx][fill_way] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
//////////////////////////////////////////////////
// data cache controller FSM
// hit service, victim writeback, block fetch
// flush walk over all blocks on halt
// drives the memory bus request levels
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
	input  logic CLK,
	input  logic nRST,
	input  logic dmem_ren,
	input  logic dmem_wen,
	input  logic halt,
	input  dcache_pkg::dcache_addr_t req_addr,
	input  logic hit,
	input  logic hit_way,
	input  logic victim_way,
	input  logic blk_dirty,
	input  logic [dcache_pkg::DTAG_W-1:0] blk_tag,
	input  dcache_pkg::word_t [dcache_pkg::BLK_WORDS-1:0] blk_data,
	input  logic last,
	input  logic [dcache_pkg::DIDX_W-1:0] flush_idx,
	input  logic bus_wait,
	output logic dhit,
	output logic flushed,
	output logic bus_ren,
	output logic bus_wen,
	output dcache_pkg::word_t bus_addr,
	output dcache_pkg::word_t bus_store,
	output dcache_pkg::word_t dmem_load,
	output logic [dcache_pkg::BLK_WORDS-1:0] fill_word,
	output logic fill_way,
	output logic wr_hit,
	output logic set_valid,
	output logic clr_dirty,
	output logic touch,
	output logic step,
	output logic clear,
	output logic flush_mode
);
	import dcache_pkg::*;

	ctrl_state_t state_q, next_state;
	logic vic_way_q;       // victim way held for the whole miss
	dcache_addr_t baddr;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= IDLE;
			vic_way_q <= 1'b0;
		end else begin
			state_q <= next_state;
			if (state_q == IDLE)
				vic_way_q <= victim_way; // frozen once we leave idle
		end
	end

	always_comb begin
		next_state = state_q;
		dhit = 1'b0;
		bus_ren = 1'b0;
		bus_wen = 1'b0;
		fill_word = '0;
		fill_way = vic_way_q;
		wr_hit = 1'b0;
		set_valid = 1'b0;
		clr_dirty = 1'b0;
		touch = 1'b0;
		step = 1'b0;
		clear = 1'b0;
		flush_mode = 1'b0;
		// default address is the word fetch for the request
		baddr.fields.tag = req_addr.fields.tag;
		baddr.fields.idx = req_addr.fields.idx;
		baddr.fields.blkoff = 1'b0;
		baddr.fields.bytoff = '0;
		bus_store = blk_data[0];

		case (state_q)
			IDLE: begin
				clear = 1'b1;
				fill_way = hit ? hit_way : victim_way;
				if (halt) begin
					next_state = FLUSH_CHK;
				end else if (dmem_ren || dmem_wen) begin
					if (hit) begin
						dhit = 1'b1;
						touch = 1'b1;
						wr_hit = dmem_wen;
					end else if (blk_dirty) begin
						next_state = WB1;
					end else begin
						next_state = FETCH1;
					end
				end
			end
			WB1, WB2: begin
				bus_wen = 1'b1;
				baddr.fields.tag = blk_tag; // victim's own address
				baddr.fields.blkoff = (state_q == WB2);
				bus_store = (state_q == WB2) ? blk_data[1] : blk_data[0];
				if (!bus_wait) begin
					if (state_q == WB1) begin
						next_state = WB2;
					end else begin
						clr_dirty = 1'b1;
						next_state = FETCH1;
					end
				end
			end
			FETCH1: begin
				bus_ren = 1'b1;
				if (!bus_wait) begin
					fill_word[0] = 1'b1;
					next_state = FETCH2;
				end
			end
			FETCH2: begin
				bus_ren = 1'b1;
				baddr.fields.blkoff = 1'b1;
				if (!bus_wait) begin
					fill_word[1] = 1'b1;
					set_valid = 1'b1; // tag goes in with the last word
					next_state = DONE;
				end
			end
			DONE: begin
				dhit = 1'b1;
				touch = 1'b1;
				wr_hit = dmem_wen; // store miss merges into the new block
				next_state = IDLE;
			end
			FLUSH_CHK: begin
				flush_mode = 1'b1;
				if (blk_dirty) begin
					next_state = FLUSH_WB1;
				end else begin
					step = 1'b1;
					if (last)
						next_state = FLUSHED;
				end
			end
			FLUSH_WB1, FLUSH_WB2: begin
				flush_mode = 1'b1;
				bus_wen = 1'b1;
				baddr.fields.tag = blk_tag;
				baddr.fields.idx = flush_idx;
				baddr.fields.blkoff = (state_q == FLUSH_WB2);
				bus_store = (state_q == FLUSH_WB2) ? blk_data[1] : blk_data[0];
				if (!bus_wait) begin
					if (state_q == FLUSH_WB1) begin
						next_state = FLUSH_WB2;
					end else begin
						clr_dirty = 1'b1;
						step = 1'b1;
						next_state = last ? FLUSHED : FLUSH_CHK;
					end
				end
			end
			FLUSHED: flush_mode = 1'b1; // parked until reset
			default: next_state = IDLE;
		endcase
	end

	assign bus_addr = baddr.raw;
	assign flushed = (state_q == FLUSHED);
	assign dmem_load = blk_data[req_addr.fields.blkoff]; // hit way or filled victim

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
//////////////////////////////////////////////////
// shared definitions for the data cache
// geometry and address field widths
// request address union, raw word or fields
// controller state encoding
//////////////////////////////////////////////////
`default_nettype none

package dcache_pkg;

	typedef logic [31:0] word_t;

	// address split, tag | index | block offset | byte offset
	localparam int DTAG_W = 26;
	localparam int DIDX_W = 3;
	localparam int DBLK_W = 1;
	localparam int DBYT_W = 2;

	localparam int NUM_SETS  = 8;
	localparam int NUM_WAYS  = 2;
	localparam int BLK_WORDS = 2;

	// same 32 bits seen as a bus address or as cache fields
	typedef union packed {
		word_t raw;
		struct packed {
			logic [DTAG_W-1:0] tag;
			logic [DIDX_W-1:0] idx;
			logic [DBLK_W-1:0] blkoff;
			logic [DBYT_W-1:0] bytoff;
		} fields;
	} dcache_addr_t;

	typedef enum logic [3:0] {
		IDLE,
		WB1,        // victim word 0 out
		WB2,        // victim word 1 out
		FETCH1,
		FETCH2,
		DONE,       // fill complete, answer the core
		FLUSH_CHK,  // look at the block under the counter
		FLUSH_WB1,
		FLUSH_WB2,
		FLUSHED
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- design/dcache_top.sv
//////////////////////////////////////////////////
// data cache top level
// controller, flush counter, array, lru table
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
	input  logic CLK,
	input  logic nRST,
	// core side
	input  logic dmem_ren,
	input  logic dmem_wen,
	input  dcache_pkg::word_t dmem_addr,
	input  dcache_pkg::word_t dmem_store,
	input  logic halt,
	output logic dhit,
	output dcache_pkg::word_t dmem_load,
	output logic flushed,
	// memory side
	output logic bus_ren,
	output logic bus_wen,
	output dcache_pkg::word_t bus_addr,
	output dcache_pkg::word_t bus_store,
	input  dcache_pkg::word_t bus_load,
	input  logic bus_wait
);
	import dcache_pkg::*;

	dcache_addr_t req_addr;
	logic hit, hit_way, victim_way, blk_dirty, last;
	logic [DTAG_W-1:0] blk_tag;
	word_t [BLK_WORDS-1:0] blk_data;
	logic [BLK_WORDS-1:0] fill_word;
	logic fill_way, wr_hit, set_valid, clr_dirty;
	logic touch, step, clear, flush_mode;
	logic [3:0] blk_sel;
	logic [NUM_WAYS-1:0] valid_pair;

	assign req_addr.raw = dmem_addr;

	dcache_ctrl u_ctrl (
		.CLK, .nRST, .dmem_ren, .dmem_wen, .halt, .req_addr,
		.hit, .hit_way, .victim_way, .blk_dirty, .blk_tag, .blk_data,
		.last, .flush_idx(blk_sel[DIDX_W-1:0]), .bus_wait,
		.dhit, .flushed, .bus_ren, .bus_wen, .bus_addr, .bus_store, .dmem_load,
		.fill_word, .fill_way, .wr_hit, .set_valid, .clr_dirty,
		.touch, .step, .clear, .flush_mode
	);

	flush_counter u_flush (
		.CLK, .nRST, .step, .clear, .blk_sel, .last
	);

	dcache_array u_array (
		.CLK, .nRST, .req_addr, .dmem_store, .fill_data(bus_load),
		.wr_hit, .fill_word, .fill_way, .set_valid, .clr_dirty, .flush_mode,
		.blk_sel, .hit, .hit_way, .blk_dirty, .blk_tag, .blk_data, .valid_pair
	);

	// touched way is whichever way the controller is steering
	lru_table u_lru (
		.CLK, .nRST, .idx(req_addr.fields.idx), .valid_pair,
		.touch, .touch_way(fill_way), .victim_way
	);

endmodule

`default_nettype wire

//--- design/flush_counter.sv
//////////////////////////////////////////////////
// block walker for the cache flush
// low bits index, top bit way
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module flush_counter (
	input  logic CLK,
	input  logic nRST,
	input  logic step,
	input  logic clear,
	output logic [3:0] blk_sel,
	output logic last
);
	import dcache_pkg::*;

	logic [3:0] blk_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			blk_q <= '0;
		else if (clear)
			blk_q <= '0;
		else if (step)
			blk_q <= blk_q + 4'd1;
	end

	assign blk_sel = blk_q;
	assign last = (blk_q == 4'(NUM_SETS * NUM_WAYS - 1)); // way 1, set 7

endmodule

`default_nettype wire

//--- design/lru_table.sv
//////////////////////////////////////////////////
// replacement table, one last-used bit per set
// victim way selection
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module lru_table (
	input  logic CLK,
	input  logic nRST,
	input  logic [dcache_pkg::DIDX_W-1:0] idx,
	input  logic [dcache_pkg::NUM_WAYS-1:0] valid_pair,
	input  logic touch,
	input  logic touch_way,
	output logic victim_way
);
	import dcache_pkg::*;

	logic [NUM_SETS-1:0] used_q; // way touched last in each set

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			used_q <= '0;
		else if (touch)
			used_q[idx] <= touch_way;
	end

	// empty way first, then the one not used last
	always_comb begin
		if (!valid_pair[0])
			victim_way = 1'b0;
		else if (!valid_pair[1])
			victim_way = 1'b1;
		else
			victim_way = ~used_q[idx];
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile the data cache testbench with Verilator and run it
verilator --binary --timing --top-module dcache_tb -f dcache.f -o dcache_sim \
	&& ./obj_dir/dcache_sim | tee /dev/stderr | grep -q "Finished with no errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/dcache_tb.sv
//////////////////////////////////////////////////
// data cache testbench
// clock, reset, watchdog, reference memory
// directed tests for hits, misses, replacement,
// dirty writeback, flush and a random mix
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	localparam int PERIOD = 4;
	localparam int NUM_REQ = 240;       // directed plus random requests
	localparam int MISS_MAX = 20;       // two writeback and two fetch words at 4 cycles each
	localparam int FLUSH_MAX = 16 * 9 + 1;
	localparam int TIMEOUT = (NUM_REQ * MISS_MAX + 2 * FLUSH_MAX + 100) * PERIOD;

	logic CLK = 1'b0;
	logic nRST;
	logic dmem_ren, dmem_wen, halt, dhit, flushed;
	word_t dmem_addr, dmem_store, dmem_load;
	logic bus_ren, bus_wen, bus_wait;
	word_t bus_addr, bus_store, bus_load;
	word_t ref_mem [256];    // expected memory as the core sees it
	int n_err = 0;
	int n_chk = 0;

	always #(PERIOD / 2) CLK = ~CLK;

	dcache_top UUT (
		.CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
		.dhit, .dmem_load, .flushed, .bus_ren, .bus_wen, .bus_addr, .bus_store,
		.bus_load, .bus_wait
	);

	mem_model MEM (
		.CLK, .nRST, .bus_ren, .bus_wen, .bus_addr, .bus_store, .bus_load, .bus_wait
	);

	function automatic word_t blk_addr(input int tag, input int idx, input int off);
		return word_t'(tag * 64 + idx * 8 + off * 4);
	endfunction

	task automatic compare(input word_t got, input word_t exp, input string what);
		n_chk++;
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			n_err++;
		end
	endtask

	task automatic expect_traffic(input int rd0, input int wr0, input int rd_exp,
			input int wr_exp, input string what);
		compare(MEM.rd_cnt - rd0, rd_exp, {what, " bus reads"});
		compare(MEM.wr_cnt - wr0, wr_exp, {what, " bus writes"});
	endtask

	task automatic verify_memory(input string what);
		for (int i = 0; i < 256; i++)
			compare(MEM.mem[i], ref_mem[i], $sformatf("%s, memory word %0d", what, i));
	endtask

	task automatic apply_reset();
		nRST = 1'b0;
		halt = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		repeat (8) @(negedge CLK);
		nRST = 1'b1;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = MEM.mem[i]; // memory comes out of reset with its fill pattern
	endtask

	// called on a falling edge and holds the request until the edge after dhit
	task automatic access(input logic wr, input word_t addr, input word_t wdata);
		int n;
		logic got;
		word_t rdata;
		n = 0;
		got = 1'b0;
		rdata = '0;
		dmem_ren = ~wr;
		dmem_wen = wr;
		dmem_addr = addr;
		dmem_store = wdata;
		while (!got && n < 4 * MISS_MAX) begin
			#1; // low phase sample before the rising edge
			if (dhit) begin
				got = 1'b1;
				rdata = dmem_load;
			end
			@(negedge CLK);
			n++;
		end
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		if (!got) begin
			$display("request to %h got no dhit within %0d cycles", addr, n);
			n_err++;
		end else if (wr) begin
			ref_mem[addr[9:2]] = wdata;
		end else begin
			compare(rdata, ref_mem[addr[9:2]], $sformatf("load from %h", addr));
		end
	endtask

	task automatic read_miss_then_hit();
		int rd0, wr0;
		rd0 = MEM.rd_cnt;
		wr0 = MEM.wr_cnt;
		access(1'b0, blk_addr(1, 2, 0), '0);
		expect_traffic(rd0, wr0, 2, 0, "read miss");
		rd0 = MEM.rd_cnt;
		access(1'b0, blk_addr(1, 2, 1), '0);  // other word of the block
		expect_traffic(rd0, wr0, 0, 0, "read hit");
		access(1'b1, blk_addr(1, 2, 1), 32'hcafe_0001);
		access(1'b0, blk_addr(1, 2, 1), '0);
		expect_traffic(rd0, wr0, 0, 0, "write hit");
	endtask

	task automatic replace_lru_way();
		int rd0, wr0;
		access(1'b0, blk_addr(1, 5, 0), '0);
		access(1'b0, blk_addr(2, 5, 0), '0);
		access(1'b0, blk_addr(1, 5, 1), '0); // tag 1 now most recent
		rd0 = MEM.rd_cnt;
		wr0 = MEM.wr_cnt;
		access(1'b0, blk_addr(3, 5, 1), '0);
		expect_traffic(rd0, wr0, 2, 0, "third tag miss");
		rd0 = MEM.rd_cnt;
		access(1'b0, blk_addr(1, 5, 0), '0);
		expect_traffic(rd0, wr0, 0, 0, "protected way");
		access(1'b0, blk_addr(2, 5, 1), '0);
		expect_traffic(rd0, wr0, 2, 0, "evicted block refetch");
		rd0 = MEM.rd_cnt;
		access(1'b0, blk_addr(3, 5, 0), '0); // tag 1 in way 0 is now the older one
		access(1'b0, blk_addr(2, 5, 0), '0);
		expect_traffic(rd0, wr0, 2, 0, "other way protected");
	endtask

	task automatic evict_dirty_block();
		int rd0, wr0, n0;
		word_t w;
		access(1'b0, blk_addr(1, 6, 0), '0);
		access(1'b1, blk_addr(1, 6, 0), 32'h1111_aaaa);
		access(1'b1, blk_addr(1, 6, 1), 32'h2222_bbbb);
		access(1'b0, blk_addr(2, 6, 0), '0);
		rd0 = MEM.rd_cnt;
		wr0 = MEM.wr_cnt;
		n0 = MEM.log_n;
		access(1'b0, blk_addr(3, 6, 1), '0);
		expect_traffic(rd0, wr0, 2, 2, "dirty eviction");
		// victim words go out first, then the new block comes in
		for (int k = 0; k < 4; k++) begin
			w = (k < 2) ? blk_addr(1, 6, k) : blk_addr(3, 6, k - 2);
			compare(MEM.log_addr[n0 + k], w, $sformatf("bus word %0d address", k));
			if (MEM.log_wr[n0 + k] !== (k < 2)) begin
				$display("[FAIL] %0t: bus word %0d has the wrong direction", $time, k);
				n_err++;
			end
		end
		for (int k = 0; k < 2; k++) begin
			w = blk_addr(1, 6, k);
			compare(MEM.mem[w[9:2]], ref_mem[w[9:2]], "written back word");
		end
	endtask

	task automatic random_mix();
		word_t a;
		for (int n = 0; n < 200; n++) begin
			a = blk_addr($urandom % 8, $urandom % 3, $urandom % 2);
			if ($urandom % 2)
				access(1'b1, a, $urandom);
			else
				access(1'b0, a, '0);
		end
	endtask

	// wr_exp below zero when the dirty count is not known
	task automatic flush_on_halt(input int wr_exp);
		int rd0, wr0, n;
		rd0 = MEM.rd_cnt;
		wr0 = MEM.wr_cnt;
		n = 0;
		halt = 1'b1;
		while (!flushed && n < 2 * FLUSH_MAX) begin
			@(negedge CLK);
			n++;
		end
		if (!flushed) begin
			$display("flushed did not rise within %0d cycles of halt", n);
			n_err++;
		end
		if (wr_exp < 0)
			compare(MEM.rd_cnt - rd0, 0, "flush bus reads");
		else
			expect_traffic(rd0, wr0, 0, wr_exp, "flush");
		verify_memory("after flush");
		repeat (5) @(negedge CLK);
		if (!flushed) begin
			$display("flushed dropped while halt was held");
			n_err++;
		end
	endtask

	initial begin
		void'($urandom(32'h868f57d3));
		nRST = 1'b0;
		halt = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		apply_reset();
		read_miss_then_hit();
		replace_lru_way();
		evict_dirty_block();
		random_mix();
		flush_on_halt(-1);
		apply_reset();
		access(1'b1, blk_addr(0, 0, 0), 32'h0bad_f00d);
		access(1'b1, blk_addr(0, 3, 1), 32'h3333_0001);
		access(1'b1, blk_addr(2, 3, 0), 32'h3333_0002); // both ways of set 3 dirty
		access(1'b0, blk_addr(4, 7, 0), '0);
		access(1'b0, blk_addr(1, 1, 1), '0);
		flush_on_halt(6);
		$display("%0d checks, %0d errors", n_chk, n_err);
		if (n_err == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired after %0d ns before the tests completed", TIMEOUT);
		$display("%0d checks, %0d errors", n_chk, n_err);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/mem_model.sv
//////////////////////////////////////////////////
// word memory on the cache bus
// 0 to 3 random wait cycles per word
// bus read and write counters, access log
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_model (
	input  logic CLK,
	input  logic nRST,
	input  logic bus_ren,
	input  logic bus_wen,
	input  dcache_pkg::word_t bus_addr,
	input  dcache_pkg::word_t bus_store,
	output dcache_pkg::word_t bus_load,
	output logic bus_wait
);
	import dcache_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int LOG_DEPTH = 2048;

	word_t mem [MEM_WORDS];
	int rd_cnt;
	int wr_cnt;
	int log_n;                  // completed bus words so far
	word_t log_addr [LOG_DEPTH];
	logic log_wr [LOG_DEPTH];
	logic [1:0] wait_cnt;       // waits left before the current word completes
	logic [7:0] widx;

	assign widx = bus_addr[9:2];
	assign bus_wait = (bus_ren || bus_wen) && (wait_cnt != 2'd0);
	assign bus_load = mem[widx];

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wait_cnt <= 2'd0;
			rd_cnt <= 0;
			wr_cnt <= 0;
			log_n <= 0;
			// fill pattern built from the full byte address
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= {~16'(i << 2), 16'(i << 2)} ^ 32'h6b43_a9b5;
		end else if (bus_ren || bus_wen) begin
			if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				wait_cnt <= 2'($urandom % 4); // stall for the next word
				if (bus_wen) begin
					mem[widx] <= bus_store;
					wr_cnt <= wr_cnt + 1;
				end else begin
					rd_cnt <= rd_cnt + 1;
				end
				if (log_n < LOG_DEPTH) begin
					log_addr[log_n[10:0]] <= bus_addr;
					log_wr[log_n[10:0]] <= bus_wen;
				end
				log_n <= log_n + 1;
			end
		end
	end

endmodule

`default_nettype wire
